// ==== online_softmax.f ====
attn_pkg.sv
score_max_tracker.sv
exp2_weight.sv
expmul_stage.sv
online_softmax_ctrl.sv
online_softmax_top.sv
online_softmax_assert.sv
tb_online_softmax.sv

// ==== Makefile ====
TOP := tb_online_softmax

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing --assert -f online_softmax.f --top-module $(TOP)

obj_dir/V$(TOP): $(shell cat online_softmax.f)
	verilator --binary --timing --assert -f online_softmax.f --top-module $(TOP) -o V$(TOP)

# sim.log is searched for the fail message after the run
sim: obj_dir/V$(TOP)
	./obj_dir/V$(TOP) +verilator+error+limit+1000 > sim.log 2>&1 || (cat sim.log; false)
	@cat sim.log
	@if grep -q "TESTS FAILED" sim.log; then exit 1; fi

clean:
	rm -rf obj_dir sim.log

// ==== tb_online_softmax.sv ====
`timescale 1ns/1ps

module tb_online_softmax
    import attn_pkg::*;
();

    localparam int dim            = 4;
    localparam int seq_len        = 8;
    localparam int n_rows         = 20;
    localparam int timeout_cycles = n_rows * (seq_len + 4) + 200;
    // score patterns of a row
    localparam int mode_uniform   = 0;
    localparam int mode_rise      = 1;
    localparam int mode_fall      = 2;
    localparam int mode_rand      = 3;

    logic             clk = 1'b0;
    logic             rst;
    logic             vld_in;
    logic             rdy_in = 1'b1;
    score_t           score;
    value_t [dim-1:0] value_vec;
    logic             rdy_out;
    logic             vld_out;
    softmax_result_t  result;

    integer seed    = 32'h667ff4d4;
    // separate stream for the sink so its stalls do not shift the stimulus
    integer bp_seed = 32'h667ff4d4 ^ 32'h3c3c3c3c;
    int     errors        = 0;
    int     rows_taken    = 0;
    int     keys_accepted = 0;
    int     cycles        = 0;
    int     stall_left    = 0;
    int     sink_rnd;
    bit     bp_en = 1'b0;

    // reference model state
    int              lut_tab [16];
    int              ref_m;
    longint          ref_o [dim];
    longint          ref_l;
    int              ref_keys = 0;
    softmax_result_t exp_q [$];

    online_softmax_top #(
        .dim     (dim),
        .seq_len (seq_len)
    ) u_online_softmax_top (
        .clk       (clk),
        .rst       (rst),
        .vld_in    (vld_in),
        .rdy_in    (rdy_in),
        .score     (score),
        .value_vec (value_vec),
        .rdy_out   (rdy_out),
        .vld_out   (vld_out),
        .result    (result)
    );

    always #4 clk = ~clk;

    // 2^(-d/16) in q1.8, d clamped to 255
    function automatic int weight_of(input int d);
        int dc;
        dc = (d > 255) ? 255 : d;
        return lut_tab[dc % 16] >> (dc / 16);
    endfunction

    // one accepted key through the fixed-point rules
    function automatic void model_key(input int s, input value_t [dim-1:0] v);
        int              m_cur;
        int              m_new;
        int              w_old;
        int              w_new;
        softmax_result_t exp_r;
        m_cur = (ref_keys == 0) ? s : ref_m;
        m_new = (s > m_cur) ? s : m_cur;
        // first key drops the old sums
        w_old = (ref_keys == 0) ? 0 : weight_of(m_new - m_cur);
        w_new = weight_of(m_new - s);
        for (int i = 0; i < dim; i++) begin
            ref_o[i] = ((longint'(w_old) * ref_o[i]) >>> 8)
                     + longint'(w_new * int'($signed(v[i])));
        end
        ref_l = ((longint'(w_old) * ref_l) >>> 8) + longint'(w_new);
        ref_m = m_new;
        ref_keys++;
        if (ref_keys == seq_len) begin
            for (int i = 0; i < dim; i++) begin
                exp_r.o[i] = acc_t'(ref_o[i]);
            end
            exp_r.l = acc_t'(ref_l);
            exp_q.push_back(exp_r);
            ref_keys = 0;
        end
    endfunction

    function automatic void check_result();
        softmax_result_t exp_r;
        assert (exp_q.size() != 0) else begin
            $display("result handshake without a completed row in the model");
            errors++;
        end
        // each result closes a row of exactly seq_len keys
        assert (keys_accepted == (rows_taken + 1) * seq_len) else begin
            $display("Fail keys_accepted got %h expected %h",
                     keys_accepted, (rows_taken + 1) * seq_len);
            errors++;
        end
        if (exp_q.size() != 0) begin
            exp_r = exp_q.pop_front();
            for (int i = 0; i < dim; i++) begin
                assert (result.o[i] == exp_r.o[i]) else begin
                    $display("Fail result.o[%0d] got %h expected %h", i, result.o[i], exp_r.o[i]);
                    errors++;
                end
            end
            assert (result.l == exp_r.l) else begin
                $display("Fail result.l got %h expected %h", result.l, exp_r.l);
                errors++;
            end
        end
        rows_taken++;
    endfunction

    task automatic close_run();
        int unsigned assert_errs;
        assert_errs = u_online_softmax_top.u_assert.fail_cnt;
        $display("check errors %0d, assertion errors %0d, rows taken %0d of %0d",
                 errors, assert_errs, rows_taken, n_rows);
        if (errors == 0 && assert_errs == 0) begin
            $display("TESTS PASSED");
        end else begin
            $display("TESTS FAILED");
        end
        $finish;
    endtask

    // hold the key until the handshake, mid-cycle rdy_out decides it
    task automatic send_key(input score_t s, input value_t [dim-1:0] v);
        bit taken;
        vld_in    = 1'b1;
        score     = s;
        value_vec = v;
        taken     = 1'b0;
        while (!taken) begin
            @(negedge clk);
            taken = rdy_out;
            @(posedge clk);
            #1;
        end
        vld_in = 1'b0;
    endtask

    task automatic send_row(input int mode, input bit gaps);
        int               rnd;
        int               rnd_v;
        score_t           s;
        value_t [dim-1:0] v;
        for (int k = 0; k < seq_len; k++) begin
            rnd = $random(seed);
            case (mode)
                mode_uniform: s = '0;
                // every key a new max
                mode_rise:    s = score_t'(-80 + k * 20 + int'(rnd[3:0]));
                // steps of 1.75, tail beyond 8.0 below the max
                mode_fall:    s = score_t'(100 - k * 28 + int'(rnd[2:0]));
                default:      s = score_t'(rnd[7:0]);
            endcase
            for (int i = 0; i < dim; i++) begin
                rnd_v = $random(seed);
                v[i] = (mode == mode_uniform) ? value_t'(1) : rnd_v[7:0];
            end
            // bubble of 0 to 2 cycles
            if (gaps && rnd[9]) begin
                repeat (int'(rnd[8]) + 1) begin
                    @(posedge clk);
                    #1;
                end
            end
            send_key(s, v);
        end
    endtask

    // model and checks sample mid-cycle
    always @(negedge clk) begin
        if (!rst) begin
            if (vld_in && rdy_out) begin
                model_key(int'(score), value_vec);
                keys_accepted++;
            end
            if (vld_out && rdy_in) begin
                check_result();
            end
        end
    end

    // downstream sink, random stall stretches of 1 to 6 cycles
    always @(posedge clk) begin
        #1;
        if (stall_left > 0) begin
            rdy_in = 1'b0;
            stall_left--;
        end else if (bp_en) begin
            sink_rnd = $random(bp_seed);
            rdy_in = (sink_rnd[1:0] != 2'd0);
            if (!rdy_in) begin
                stall_left = int'(sink_rnd[4:2]) % 6;
            end
        end else begin
            rdy_in = 1'b1;
        end
    end

    always @(posedge clk) begin
        cycles++;
        if (cycles >= timeout_cycles) begin
            $display("timeout after %0d cycles with %0d rows taken", cycles, rows_taken);
            errors++;
            close_run();
        end
    end

    initial begin
        rst       = 1'b1;
        vld_in    = 1'b0;
        score     = '0;
        value_vec = '0;
        for (int f = 0; f < 16; f++) begin
            lut_tab[f] = $rtoi(256.0 * (2.0 ** (-real'(f) / 16.0)) + 0.5);
        end
        repeat (16) @(posedge clk);
        #1;
        rst = 1'b0;
        @(negedge clk);
        assert (vld_out == 1'b0) else begin
            $display("Fail vld_out got %h expected 0", vld_out);
            errors++;
        end
        assert (rdy_out == 1'b1) else begin
            $display("Fail rdy_out got %h expected 1", rdy_out);
            errors++;
        end
        @(posedge clk);
        #1;
        repeat (2) send_row(mode_uniform, 1'b0);
        repeat (3) send_row(mode_rise, 1'b0);
        repeat (3) send_row(mode_fall, 1'b0);
        repeat (4) send_row(mode_rand, 1'b0);
        bp_en = 1'b1;
        repeat (4) send_row(mode_rand, 1'b0);
        // bubbles under back-pressure, rows back to back
        repeat (4) send_row(mode_rand, 1'b1);
        while (rows_taken < n_rows) begin
            @(posedge clk);
        end
        close_run();
    end

endmodule

// ==== online_softmax_assert.sv ====
`timescale 1ns/1ps

module online_softmax_assert
    import attn_pkg::*;
#(
    parameter int seq_len = 8
) (
    input logic            clk,
    input logic            rst,
    input logic            accept,
    input logic            rdy_in,
    input logic            rdy_out,
    input logic            vld_out,
    input softmax_result_t result
);

    // failed assertions, read by the testbench
    int unsigned fail_cnt = 0;
    // keys accepted so far in this row
    int unsigned key_cnt;
    logic        last_key;

    assign last_key = accept && (key_cnt == seq_len - 1);

    always_ff @(posedge clk) begin
        if (rst) begin
            key_cnt <= 0;
        end else if (accept) begin
            key_cnt <= last_key ? 0 : key_cnt + 1;
        end
    end

    // held result must not move under back-pressure
    a_result_stable: assert property (@(posedge clk) disable iff (rst)
        vld_out && !rdy_in |=> $stable(result))
    else begin
        $error("result changed while vld_out high and rdy_in low");
        fail_cnt++;
    end

    // result waits with upstream stalled until taken
    a_hold_until_taken: assert property (@(posedge clk) disable iff (rst)
        vld_out && !rdy_in |=> vld_out && !rdy_out)
    else begin
        $error("result dropped or rdy_out high before the result was taken");
        fail_cnt++;
    end

    // last key of a row, result one cycle later
    a_result_latency: assert property (@(posedge clk) disable iff (rst)
        last_key |=> vld_out)
    else begin
        $error("vld_out not high one cycle after the last key");
        fail_cnt++;
    end

    a_result_cause: assert property (@(posedge clk) disable iff (rst)
        $rose(vld_out) |-> $past(last_key))
    else begin
        $error("vld_out rose without a completed row");
        fail_cnt++;
    end

    // idle outputs while reset is held
    a_reset_values: assert property (@(posedge clk)
        rst && $past(rst) |-> !vld_out && rdy_out)
    else begin
        $error("vld_out or rdy_out wrong during reset");
        fail_cnt++;
    end

endmodule

bind online_softmax_top online_softmax_assert #(
    .seq_len (seq_len)
) u_assert (
    .clk     (clk),
    .rst     (rst),
    .accept  (accept),
    .rdy_in  (rdy_in),
    .rdy_out (rdy_out),
    .vld_out (vld_out),
    .result  (result)
);

// ==== online_softmax_top.sv ====
`timescale 1ns/1ps

module online_softmax_top
    import attn_pkg::*;
#(
    parameter int dim     = 4,
    parameter int seq_len = 8
) (
    input  logic             clk,
    input  logic             rst,
    input  logic             vld_in,
    input  logic             rdy_in,
    input  score_t           score,
    input  value_t [dim-1:0] value_vec,
    output logic             rdy_out,
    output logic             vld_out,
    output softmax_result_t  result
);

    // struct width is fixed in the package
    if (dim != max_dim) begin : g_dim_check
        $error("dim must equal attn_pkg::max_dim");
    end

    logic             accept;
    logic             first;
    diff_t            diff_old;
    diff_t            diff_new;
    weight_t          w_old;
    weight_t          w_new;
    acc_t [dim-1:0]   o_vec;
    acc_t             l_sum;

    online_softmax_ctrl #(
        .seq_len (seq_len)
    ) u_ctrl (
        .clk     (clk),
        .rst     (rst),
        .vld_in  (vld_in),
        .rdy_in  (rdy_in),
        .rdy_out (rdy_out),
        .vld_out (vld_out),
        .accept  (accept),
        .first   (first)
    );

    score_max_tracker u_max (
        .clk      (clk),
        .rst      (rst),
        .accept   (accept),
        .first    (first),
        .score    (score),
        .diff_old (diff_old),
        .diff_new (diff_new)
    );

    // rescale factor for the old sums
    exp2_weight u_exp_old (
        .diff   (diff_old),
        .weight (w_old)
    );

    // weight of the incoming key
    exp2_weight u_exp_new (
        .diff   (diff_new),
        .weight (w_new)
    );

    expmul_stage #(
        .dim (dim)
    ) u_expmul (
        .clk       (clk),
        .rst       (rst),
        .accept    (accept),
        .first     (first),
        .w_old     (w_old),
        .w_new     (w_new),
        .value_vec (value_vec),
        .o_vec     (o_vec),
        .l_sum     (l_sum)
    );

    // unnormalized o and l for the divider downstream
    assign result.o = o_vec;
    assign result.l = l_sum;

endmodule

// ==== online_softmax_ctrl.sv ====
`timescale 1ns/1ps

module online_softmax_ctrl
    import attn_pkg::*;
#(
    parameter int seq_len = 8
) (
    input  logic clk,
    input  logic rst,
    input  logic vld_in,
    input  logic rdy_in,
    output logic rdy_out,
    output logic vld_out,
    output logic accept,
    output logic first
);

    // counter wide enough for seq_len - 1
    localparam int cnt_w = (seq_len > 1) ? $clog2(seq_len) : 1;

    ctrl_state_t      state;
    // keys still to come in this row
    logic [cnt_w-1:0] cnt;

    // stall upstream while the result waits
    assign rdy_out = (state != st_hold);
    assign vld_out = (state == st_hold);

    // handshake strobe
    assign accept = vld_in && rdy_out;
    // idle accept opens a row
    assign first  = accept && (state == st_idle);

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= st_idle;
            cnt   <= '0;
        end else begin
            case (state)
                st_idle: begin
                    if (accept) begin
                        if (seq_len == 1) begin
                            state <= st_hold;
                        end else begin
                            state <= st_accum;
                            cnt   <= cnt_w'(seq_len - 1);
                        end
                    end
                end
                st_accum: begin
                    if (accept) begin
                        // last key of the row
                        if (cnt == cnt_w'(1)) begin
                            state <= st_hold;
                        end
                        cnt <= cnt - 1'b1;
                    end
                end
                st_hold: begin
                    // result taken, next row may start
                    if (rdy_in) begin
                        state <= st_idle;
                    end
                end
                default: begin
                    state <= st_idle;
                    cnt   <= '0;
                end
            endcase
        end
    end

endmodule

// ==== expmul_stage.sv ====
`timescale 1ns/1ps

module expmul_stage
    import attn_pkg::*;
#(
    parameter int dim = 4
) (
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 accept,
    input  logic                 first,
    input  weight_t              w_old,
    input  weight_t              w_new,
    input  value_t [dim-1:0]     value_vec,
    output acc_t   [dim-1:0]     o_vec,
    output acc_t                 l_sum
);

    // weights as signed operands
    logic signed [9:0]  w_old_s;
    logic signed [9:0]  w_new_s;
    // rescaled old terms, still with 8 extra fraction bits
    logic signed [33:0] old_prod [dim];
    // new key term, q.8 already
    logic signed [17:0] new_prod [dim];
    logic signed [33:0] l_old_prod;
    acc_t [dim-1:0]     o_next;
    acc_t               l_next;

    // first key of a row drops the old sums
    assign w_old_s = first ? '0 : $signed({1'b0, w_old});
    assign w_new_s = $signed({1'b0, w_new});

    always_comb begin
        for (int i = 0; i < dim; i++) begin
            old_prod[i] = w_old_s * o_vec[i];
            new_prod[i] = w_new_s * value_vec[i];
            // o = (w_old * o) >>> 8 + w_new * v
            o_next[i] = acc_t'(old_prod[i] >>> 8) + acc_t'(new_prod[i]);
        end
        l_old_prod = w_old_s * l_sum;
        // l = (w_old * l) >>> 8 + w_new
        l_next = acc_t'(l_old_prod >>> 8) + acc_t'({1'b0, w_new});
    end

    // all elements and l update together
    always_ff @(posedge clk) begin
        if (rst) begin
            o_vec <= '0;
            l_sum <= '0;
        end else if (accept) begin
            o_vec <= o_next;
            l_sum <= l_next;
        end
    end

endmodule

// ==== exp2_weight.sv ====
`timescale 1ns/1ps

module exp2_weight
    import attn_pkg::*;
(
    input  diff_t   diff,
    output weight_t weight
);

    // 2^(-d) = 2^(-frac) >> int
    logic [3:0] int_part;
    logic [3:0] frac_part;
    weight_t    lut_w;

    assign int_part  = diff[7:4];
    assign frac_part = diff[3:0];

    // fractional nibble from the table
    assign lut_w = exp2_frac_lut(frac_part);

    // integer nibble as a right shift
    // nine or more shifts empty the q1.8 word
    assign weight = lut_w >> int_part;

endmodule

// ==== score_max_tracker.sv ====
`timescale 1ns/1ps

module score_max_tracker
    import attn_pkg::*;
(
    input  logic   clk,
    input  logic   rst,
    input  logic   accept,
    input  logic   first,
    input  score_t score,
    output diff_t  diff_old,
    output diff_t  diff_new
);

    // running maximum of the row
    score_t            m_reg;
    score_t            m_cur;
    score_t            m_new;
    logic signed [9:0] d_old;
    logic signed [9:0] d_new;

    // first key compares against itself
    assign m_cur = first ? score : m_reg;
    assign m_new = (score > m_cur) ? score : m_cur;

    // m_new minus the old max and minus the score, never negative
    assign d_old = 10'(m_new) - 10'(m_cur);
    assign d_new = 10'(m_new) - 10'(score);

    // clamp to 8 bits
    assign diff_old = (d_old > 10'sd255) ? 8'hff : d_old[7:0];
    assign diff_new = (d_new > 10'sd255) ? 8'hff : d_new[7:0];

    always_ff @(posedge clk) begin
        if (rst) begin
            m_reg <= '0;
        end else if (accept) begin
            m_reg <= m_new;
        end
    end

endmodule

// ==== attn_pkg.sv ====
package attn_pkg;

    // q4.4 signed score, also the running max
    typedef logic signed [7:0] score_t;
    // non-negative score difference in q4.4
    typedef logic [7:0] diff_t;
    // q1.8 weight, 256 is one
    typedef logic [8:0] weight_t;
    // integer value element
    typedef logic signed [7:0] value_t;
    // accumulator element with 8 fraction bits
    typedef logic signed [23:0] acc_t;

    // struct width, top must match
    parameter int max_dim = 4;

    typedef enum logic [1:0] {
        st_idle,
        st_accum,
        st_hold
    } ctrl_state_t;

    // o elements in the upper bits, l at the bottom
    typedef struct packed {
        acc_t [max_dim-1:0] o;
        acc_t               l;
    } softmax_result_t;

    // round(256 * 2^(-f/16))
    function automatic weight_t exp2_frac_lut(input logic [3:0] frac);
        weight_t w;
        case (frac)
            4'd0:    w = 9'd256;
            4'd1:    w = 9'd245;
            4'd2:    w = 9'd235;
            4'd3:    w = 9'd225;
            4'd4:    w = 9'd215;
            4'd5:    w = 9'd206;
            4'd6:    w = 9'd197;
            4'd7:    w = 9'd189;
            4'd8:    w = 9'd181;
            4'd9:    w = 9'd173;
            4'd10:   w = 9'd166;
            4'd11:   w = 9'd159;
            4'd12:   w = 9'd152;
            4'd13:   w = 9'd146;
            4'd14:   w = 9'd140;
            default: w = 9'd134;
        endcase
        return w;
    endfunction

endpackage
